//--- csrng_config.svh
/*
 * Build-time sizing for the CSRNG service.
 * Include this header wherever the application count or word widths are needed.
 */

`ifndef CSRNG_CONFIG_SVH
`define CSRNG_CONFIG_SVH

// Number of hardware application ports
`define CSRNG_NUM_HW_APPS 2

// Command and genbits word width
`define CSRNG_WORD_W 32

// Generate length field width in the header
`define CSRNG_GLEN_W 12

// Largest legal additional-data length, in words
`define CSRNG_MAX_CLEN 1

`endif

//--- csrng_pkg.sv
/*
 * Shared types for the CSRNG service.
 * Holds command codes, the header layout, the header/data word union
 * and the command and per-application state records.
 */

`include "csrng_config.svh"

package csrng_pkg;

  // Application command codes, every other value is illegal
  typedef enum logic [3:0] {
    ACMD_INS = 4'h1,
    ACMD_GEN = 4'h2,
    ACMD_UNI = 4'h3
  } acmd_e;

  // Command header word
  typedef struct packed {
    logic [7:0]               reserved;
    logic [`CSRNG_GLEN_W-1:0] glen;
    logic [3:0]               flags;
    logic [3:0]               clen;
    acmd_e                    acmd;
  } csrng_hdr_t;

  // First word is a header, the optional second word is raw data
  typedef union packed {
    csrng_hdr_t               hdr;
    logic [`CSRNG_WORD_W-1:0] data;
  } csrng_word_u;

  // Complete command as handed to the core
  typedef struct packed {
    acmd_e                    acmd;
    logic [3:0]               clen;
    logic [`CSRNG_GLEN_W-1:0] glen;
    logic [`CSRNG_WORD_W-1:0] adata;
  } csrng_cmd_t;

  // Per-application DRBG state
  typedef struct packed {
    logic [`CSRNG_WORD_W-1:0] key;
    logic [`CSRNG_WORD_W-1:0] v;
    logic                     inst;
  } csrng_state_t;

endpackage

//--- csrng_app_if.sv
/*
 * Link between one application command stage and the core.
 * The stage presents whole commands, the core answers with grant,
 * status and generated words.
 */

`include "csrng_config.svh"

interface csrng_app_if;
  import csrng_pkg::*;

  // Command path
  logic                     cmd_valid;
  csrng_cmd_t               cmd;
  logic                     cmd_ready;

  // Response path
  logic                     rsp_ack;
  logic                     rsp_sts;
  logic                     gen_valid;
  logic [`CSRNG_WORD_W-1:0] gen_bits;

  modport stage (
    output cmd_valid, cmd,
    input  cmd_ready, rsp_ack, rsp_sts, gen_valid, gen_bits
  );

  modport core (
    input  cmd_valid, cmd,
    output cmd_ready, rsp_ack, rsp_sts, gen_valid, gen_bits
  );

endinterface

//--- csrng_cmd_stage.sv
/*
 * Per-application command assembler.
 * Collects a header and optional data word, holds the finished command
 * for the core and blocks new words until the command is acknowledged.
 */

`include "csrng_config.svh"

module csrng_cmd_stage (
  input  logic                     clk_i,
  input  logic                     rst_i,

  // Application word input
  input  logic                     req_valid_i,
  input  csrng_pkg::csrng_word_u   req_word_i,
  output logic                     req_ready_o,

  // Core side
  csrng_app_if.stage               app,

  // Application response
  output logic                     rsp_ack_o,
  output logic                     rsp_sts_o,
  output logic                     genbits_valid_o,
  output logic [`CSRNG_WORD_W-1:0] genbits_o
);
  import csrng_pkg::*;

  typedef enum logic [1:0] {
    ST_HDR,
    ST_DATA,
    ST_CMD,
    ST_WAIT
  } stage_st_e;

  stage_st_e  st_q;
  csrng_cmd_t cmd_q;
  logic       hdr_take;
  logic       data_take;
  logic       hdr_has_data;

  assign hdr_take  = (st_q == ST_HDR) && req_valid_i;
  assign data_take = (st_q == ST_DATA) && req_valid_i;

  // Only a legal non-zero clen pulls in a data word
  assign hdr_has_data = (req_word_i.hdr.clen != 4'd0) &&
                        (req_word_i.hdr.clen <= 4'(`CSRNG_MAX_CLEN));

  ////////////////////
  // Word collection
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      st_q <= ST_HDR;
    end else begin
      case (st_q)
        ST_HDR: begin
          if (req_valid_i) begin
            st_q <= hdr_has_data ? ST_DATA : ST_CMD;
          end
        end
        ST_DATA: begin
          if (req_valid_i) begin
            st_q <= ST_CMD;
          end
        end
        ST_CMD: begin
          if (app.cmd_ready) begin
            st_q <= ST_WAIT;
          end
        end
        default: begin
          if (app.rsp_ack) begin
            st_q <= ST_HDR;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (hdr_take) begin
      cmd_q.acmd  <= req_word_i.hdr.acmd;
      cmd_q.clen  <= req_word_i.hdr.clen;
      cmd_q.glen  <= req_word_i.hdr.glen;
      cmd_q.adata <= '0;
    end else if (data_take) begin
      cmd_q.adata <= req_word_i.data;
    end
  end

  assign req_ready_o   = (st_q == ST_HDR) || (st_q == ST_DATA);
  assign app.cmd_valid = (st_q == ST_CMD);
  assign app.cmd       = cmd_q;

  // Response back to the application
  assign rsp_ack_o       = app.rsp_ack;
  assign rsp_sts_o       = app.rsp_sts;
  assign genbits_valid_o = app.gen_valid;
  assign genbits_o       = app.gen_bits;

endmodule

//--- csrng_drbg_gen.sv
/*
 * Counter-mode generate engine.
 * A start pulse loads key, counter and length; one word follows per cycle
 * and done marks the last word together with the updated key and counter.
 */

`include "csrng_config.svh"

module csrng_drbg_gen (
  input  logic                     clk_i,
  input  logic                     rst_i,

  input  logic                     start_i,
  input  logic [`CSRNG_WORD_W-1:0] key_i,
  input  logic [`CSRNG_WORD_W-1:0] v_i,
  input  logic [`CSRNG_GLEN_W-1:0] glen_i,

  output logic                     word_valid_o,
  output logic [`CSRNG_WORD_W-1:0] word_o,
  output logic                     done_o,
  output logic [`CSRNG_WORD_W-1:0] key_o,
  output logic [`CSRNG_WORD_W-1:0] v_o
);

  localparam int W = `CSRNG_WORD_W;

  logic                     busy_q;
  logic [`CSRNG_GLEN_W-1:0] cnt_q;
  logic [W-1:0]             key_q;
  logic [W-1:0]             v_q;
  logic [W-1:0]             v_next;
  logic [W-1:0]             mix;

  // Output rule: rotl7(key ^ v) + v, with v already stepped
  assign v_next = v_q + W'(1);
  assign mix    = key_q ^ v_next;
  assign word_o = {mix[W-8:0], mix[W-1:W-7]} + v_next;

  assign word_valid_o = busy_q;
  assign done_o       = busy_q && (cnt_q == `CSRNG_GLEN_W'(1));
  assign key_o        = key_q ^ word_o;
  assign v_o          = v_next;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= (glen_i != '0);
      cnt_q  <= glen_i;
    end else if (busy_q) begin
      cnt_q <= cnt_q - `CSRNG_GLEN_W'(1);
      if (done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Working key and counter
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      key_q <= key_i;
      v_q   <= v_i;
    end else if (busy_q) begin
      v_q <= v_next;
    end
  end

endmodule

//--- csrng_core.sv
/*
 * CSRNG command core.
 * Grants pending application commands round-robin, keeps one DRBG state
 * per application, fetches entropy for INS, runs the generator for GEN
 * and raises a sticky fatal alert on illegal commands.
 */

`include "csrng_config.svh"

module csrng_core (
  input  logic                     clk_i,
  input  logic                     rst_i,

  csrng_app_if.core                apps [`CSRNG_NUM_HW_APPS],

  // Entropy source
  output logic                     es_req_o,
  input  logic                     es_ack_i,
  input  logic [`CSRNG_WORD_W-1:0] es_bits_i,

  output logic                     alert_fatal_o
);
  import csrng_pkg::*;

  localparam int NApps = `CSRNG_NUM_HW_APPS;
  localparam int AppW  = (NApps > 1) ? $clog2(NApps) : 1;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DISP,
    ST_ES,
    ST_GEN,
    ST_RESP
  } core_st_e;

  core_st_e                 st_q, st_d;
  logic [AppW-1:0]          cur_q, rr_q, pick;
  logic                     found;
  logic                     sts_q, sts_d;
  logic                     alert_q, alert_d;

  logic [NApps-1:0]         cmd_valid_vec;
  csrng_cmd_t               cmd_vec [NApps];
  csrng_state_t             state_q [NApps];
  csrng_cmd_t               cur_cmd;
  csrng_state_t             cur_state;
  csrng_state_t             wr_state;
  logic                     wr_en;
  logic                     cmd_legal;

  logic                     gen_start;
  logic                     gen_valid;
  logic [`CSRNG_WORD_W-1:0] gen_word;
  logic                     gen_done;
  logic [`CSRNG_WORD_W-1:0] gen_key;
  logic [`CSRNG_WORD_W-1:0] gen_v;

  ////////////////////
  // Application ports
  ////////////////////
  for (genvar i = 0; i < NApps; i++) begin : gen_app_io
    assign cmd_valid_vec[i]  = apps[i].cmd_valid;
    assign cmd_vec[i]        = apps[i].cmd;
    assign apps[i].cmd_ready = (st_q == ST_DISP) && (cur_q == AppW'(i));
    assign apps[i].rsp_ack   = (st_q == ST_RESP) && (cur_q == AppW'(i));
    assign apps[i].rsp_sts   = sts_q;
    assign apps[i].gen_valid = gen_valid && (cur_q == AppW'(i));
    assign apps[i].gen_bits  = gen_word;
  end

  assign cur_cmd   = cmd_vec[cur_q];
  assign cur_state = state_q[cur_q];
  assign cmd_legal = ((cur_cmd.acmd == ACMD_INS) ||
                      (cur_cmd.acmd == ACMD_GEN) ||
                      (cur_cmd.acmd == ACMD_UNI)) &&
                     (cur_cmd.clen <= 4'(`CSRNG_MAX_CLEN));

  // Round-robin search starting at the priority pointer
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = '0;
    for (int k = 0; k < NApps; k++) begin
      idx = (int'(rr_q) + k) % NApps;
      if (!found && cmd_valid_vec[idx]) begin
        found = 1'b1;
        pick  = AppW'(idx);
      end
    end
  end

  ////////////////////
  // Command FSM
  ////////////////////
  always_comb begin
    st_d      = st_q;
    sts_d     = sts_q;
    alert_d   = alert_q;
    wr_en     = 1'b0;
    wr_state  = cur_state;
    gen_start = 1'b0;
    case (st_q)
      ST_IDLE: begin
        if (found) begin
          st_d = ST_DISP;
        end
      end
      ST_DISP: begin
        sts_d = 1'b0;
        st_d  = ST_RESP;
        if (!cmd_legal) begin
          sts_d   = 1'b1;
          alert_d = 1'b1;
        end else if (cur_cmd.acmd == ACMD_INS) begin
          st_d = ST_ES;
        end else if (cur_cmd.acmd == ACMD_UNI) begin
          wr_en    = 1'b1;
          wr_state = '0;
        end else if (!cur_state.inst) begin
          // GEN without an instance, refused without alert
          sts_d = 1'b1;
        end else if (cur_cmd.glen == '0) begin
          wr_en        = 1'b1;
          wr_state.key = cur_state.key ^ cur_cmd.adata;
        end else begin
          gen_start = 1'b1;
          st_d      = ST_GEN;
        end
      end
      ST_ES: begin
        if (es_ack_i) begin
          wr_en         = 1'b1;
          wr_state.key  = es_bits_i ^ cur_cmd.adata;
          wr_state.v    = '0;
          wr_state.inst = 1'b1;
          st_d          = ST_RESP;
        end
      end
      ST_GEN: begin
        if (gen_done) begin
          wr_en        = 1'b1;
          wr_state.key = gen_key;
          wr_state.v   = gen_v;
          st_d         = ST_RESP;
        end
      end
      default: begin
        st_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      st_q    <= ST_IDLE;
      cur_q   <= '0;
      rr_q    <= '0;
      sts_q   <= 1'b0;
      alert_q <= 1'b0;
    end else begin
      st_q    <= st_d;
      sts_q   <= sts_d;
      alert_q <= alert_d;
      if ((st_q == ST_IDLE) && found) begin
        cur_q <= pick;
        rr_q  <= AppW'((int'(pick) + 1) % NApps);
      end
    end
  end

  // State store, cleared so every application starts uninstantiated
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NApps; i++) begin
        state_q[i] <= '0;
      end
    end else if (wr_en) begin
      state_q[cur_q] <= wr_state;
    end
  end

  csrng_drbg_gen u_drbg_gen (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (gen_start),
    .key_i        (cur_state.key ^ cur_cmd.adata),
    .v_i          (cur_state.v),
    .glen_i       (cur_cmd.glen),
    .word_valid_o (gen_valid),
    .word_o       (gen_word),
    .done_o       (gen_done),
    .key_o        (gen_key),
    .v_o          (gen_v)
  );

  assign es_req_o      = (st_q == ST_ES);
  assign alert_fatal_o = alert_q;

endmodule

//--- csrng.sv
/*
 * CSRNG service top level.
 * One command stage per hardware application feeds the shared core;
 * all application signals are plain arrays indexed by application.
 */

`include "csrng_config.svh"

module csrng (
  input  logic                                              clk_i,
  input  logic                                              rst_i,

  // Application ports
  input  logic [`CSRNG_NUM_HW_APPS-1:0]                     app_req_valid_i,
  input  logic [`CSRNG_NUM_HW_APPS-1:0][`CSRNG_WORD_W-1:0]  app_req_word_i,
  output logic [`CSRNG_NUM_HW_APPS-1:0]                     app_req_ready_o,
  output logic [`CSRNG_NUM_HW_APPS-1:0]                     app_rsp_ack_o,
  output logic [`CSRNG_NUM_HW_APPS-1:0]                     app_rsp_sts_o,
  output logic [`CSRNG_NUM_HW_APPS-1:0]                     app_genbits_valid_o,
  output logic [`CSRNG_NUM_HW_APPS-1:0][`CSRNG_WORD_W-1:0]  app_genbits_o,

  // Entropy source
  output logic                                              es_req_o,
  input  logic                                              es_ack_i,
  input  logic [`CSRNG_WORD_W-1:0]                          es_bits_i,

  output logic                                              alert_fatal_o
);

  csrng_app_if app_if [`CSRNG_NUM_HW_APPS] ();

  for (genvar i = 0; i < `CSRNG_NUM_HW_APPS; i++) begin : gen_cmd_stage
    csrng_cmd_stage u_cmd_stage (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .req_valid_i     (app_req_valid_i[i]),
      .req_word_i      (app_req_word_i[i]),
      .req_ready_o     (app_req_ready_o[i]),
      .app             (app_if[i]),
      .rsp_ack_o       (app_rsp_ack_o[i]),
      .rsp_sts_o       (app_rsp_sts_o[i]),
      .genbits_valid_o (app_genbits_valid_o[i]),
      .genbits_o       (app_genbits_o[i])
    );
  end

  // Shared core, alert level comes straight from its sticky register
  csrng_core u_csrng_core (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .apps          (app_if),
    .es_req_o      (es_req_o),
    .es_ack_i      (es_ack_i),
    .es_bits_i     (es_bits_i),
    .alert_fatal_o (alert_fatal_o)
  );

endmodule

//--- tb_csrng.sv
/*
 * Testbench for the CSRNG service.
 * Directed and random commands on both applications are checked against a
 * reference model, while an entropy responder answers es_req_o after random delays.
 */

`include "csrng_config.svh"

module tb_csrng;
  timeunit 1ns;
  timeprecision 100ps;
  import csrng_pkg::*;

  localparam int          n_apps     = `CSRNG_NUM_HW_APPS;
  localparam int          w          = `CSRNG_WORD_W;
  localparam logic [31:0] seed       = 32'd37;
  localparam int          n_directed = 14;
  localparam int          n_random   = 60;
  localparam int          n_cmds     = n_directed + n_apps * n_random;
  localparam int          wd_cycles  = n_cmds * 40 + 1000;
  localparam int          ack_limit  = 60;

  logic                     clk;
  logic                     rst;
  logic [n_apps-1:0]        req_valid;
  logic [n_apps-1:0][w-1:0] req_word;
  logic [n_apps-1:0]        req_ready;
  logic [n_apps-1:0]        rsp_ack;
  logic [n_apps-1:0]        rsp_sts;
  logic [n_apps-1:0]        gen_valid;
  logic [n_apps-1:0][w-1:0] gen_bits;
  logic                     es_req;
  logic                     es_ack;
  logic [w-1:0]             es_bits;
  logic                     alert_fatal;

  // Reference model, one DRBG state per application
  logic [w-1:0] m_key [n_apps];
  logic [w-1:0] m_v [n_apps];
  logic         m_inst [n_apps];
  logic         alert_exp;
  logic [w-1:0] es_word;

  // Words expected from the command in flight
  logic [w-1:0] exp_words [n_apps][16];
  int           exp_cnt [n_apps];
  int           exp_rd [n_apps];

  int err_check;
  int err_other;

  csrng csrng_i (
    .clk_i               (clk),
    .rst_i               (rst),
    .app_req_valid_i     (req_valid),
    .app_req_word_i      (req_word),
    .app_req_ready_o     (req_ready),
    .app_rsp_ack_o       (rsp_ack),
    .app_rsp_sts_o       (rsp_sts),
    .app_genbits_valid_o (gen_valid),
    .app_genbits_o       (gen_bits),
    .es_req_o            (es_req),
    .es_ack_i            (es_ack),
    .es_bits_i           (es_bits),
    .alert_fatal_o       (alert_fatal)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Output word for an already stepped counter
  function automatic logic [w-1:0] model_word(input logic [w-1:0] key, input logic [w-1:0] v);
    logic [w-1:0] x;
    x = key ^ v;
    return ((x << 7) | (x >> (w - 7))) + v;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_genbits(input int app, input csrng_word_u got, input csrng_word_u exp);
    if (got !== exp) begin
      err_check++;
      $display("CHECK FAILED: app_genbits_o[%0d] got 0x%08h expected 0x%08h",
               app, got.data, exp.data);
    end
  endtask

  task automatic check_sts(input int app, input logic got, input logic exp);
    if (got !== exp) begin
      err_check++;
      $display("CHECK FAILED: app_rsp_sts_o[%0d] got 0x%h expected 0x%h", app, got, exp);
    end
  endtask

  task automatic check_alert(input logic got, input logic exp);
    if (got !== exp) begin
      err_check++;
      $display("CHECK FAILED: alert_fatal_o got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic check_reset_state();
    if (req_ready !== '1 || rsp_ack !== '0 || gen_valid !== '0 ||
        es_req !== 1'b0 || alert_fatal !== 1'b0) begin
      err_other++;
      $display("ERROR: outputs after reset are not in their idle state");
    end
  endtask

  // One word over the valid/ready handshake, called on a falling edge
  task automatic send_word(input int app, input logic [w-1:0] word);
    while (!req_ready[app]) begin
      @(negedge clk);
    end
    req_valid[app] = 1'b1;
    req_word[app]  = word;
    @(negedge clk);
    req_valid[app] = 1'b0;
  endtask

  ////////////////////
  // Command with model update
  ////////////////////
  task automatic do_cmd(input int app, input logic [3:0] acmd, input logic [3:0] clen,
                        input logic [11:0] glen, input logic [w-1:0] adata,
                        input logic [11:0] junk);
    csrng_word_u  hw;
    logic         legal;
    logic         exp_sts;
    logic [w-1:0] ad;
    logic [w-1:0] k;
    logic [w-1:0] v;
    logic         done;
    int           waited;

    legal = ((acmd == ACMD_INS) || (acmd == ACMD_GEN) || (acmd == ACMD_UNI)) &&
            (clen <= 4'(`CSRNG_MAX_CLEN));
    ad = (clen == 4'd1) ? adata : '0;
    exp_sts = 1'b0;
    exp_cnt[app] = 0;
    exp_rd[app] = 0;
    if (!legal) begin
      exp_sts = 1'b1;
    end else if (acmd == ACMD_GEN) begin
      if (!m_inst[app]) begin
        exp_sts = 1'b1;
      end else begin
        k = m_key[app] ^ ad;
        v = m_v[app];
        for (int n = 0; n < int'(glen); n++) begin
          v = v + 32'd1;
          exp_words[app][n] = model_word(k, v);
        end
        if (glen != 12'd0) begin
          k = k ^ exp_words[app][int'(glen) - 1];
        end
        m_key[app] = k;
        m_v[app] = v;
        exp_cnt[app] = int'(glen);
      end
    end else if (acmd == ACMD_UNI) begin
      m_key[app] = '0;
      m_v[app] = '0;
      m_inst[app] = 1'b0;
    end

    hw.data = '0;
    hw.hdr.acmd = acmd_e'(acmd);
    hw.hdr.clen = clen;
    hw.hdr.flags = junk[3:0];
    hw.hdr.glen = glen;
    hw.hdr.reserved = junk[11:4];
    send_word(app, hw.data);
    if (clen == 4'd1) begin
      send_word(app, adata);
    end

    // Ready must stay low until the ack cycle
    done = 1'b0;
    waited = 0;
    while (!done) begin
      if (req_ready[app]) begin
        err_other++;
        $display("ERROR: app %0d accepts words while its command is pending", app);
      end
      if (rsp_ack[app]) begin
        done = 1'b1;
      end else if (waited >= ack_limit) begin
        err_other++;
        $display("ERROR: app %0d got no ack within %0d cycles", app, ack_limit);
        done = 1'b1;
      end else begin
        @(negedge clk);
        waited++;
      end
    end

    if (rsp_ack[app]) begin
      check_sts(app, rsp_sts[app], exp_sts);
      if (exp_rd[app] != exp_cnt[app]) begin
        err_other++;
        $display("ERROR: app %0d saw %0d of %0d words before its ack",
                 app, exp_rd[app], exp_cnt[app]);
      end
      if (legal && acmd == ACMD_INS) begin
        m_key[app] = es_word ^ ad;
        m_v[app] = '0;
        m_inst[app] = 1'b1;
      end
      if (!legal) begin
        alert_exp = 1'b1;
      end
      check_alert(alert_fatal, alert_exp);
    end
  endtask

  task automatic run_random(input int app, input int count);
    logic [31:0]  rs;
    logic [3:0]   sel;
    logic [3:0]   acmd;
    logic [3:0]   clen;
    logic [11:0]  glen;
    logic [11:0]  junk;
    logic [w-1:0] adata;

    rs = seed + 32'(app) * 32'h9e37_79b9;
    for (int i = 0; i < count; i++) begin
      rs = xorshift(rs);
      glen = 12'(rs % 32'd9);
      sel = rs[15:12];
      clen = {3'b000, rs[8]};
      junk = rs[31:20];
      rs = xorshift(rs);
      adata = rs;
      case (sel) inside
        [4'd0:4'd3]:   acmd = ACMD_INS;
        [4'd11:4'd12]: acmd = ACMD_UNI;
        4'd13:         acmd = {1'b1, junk[6:4]};
        4'd14: begin
          acmd = ACMD_GEN;
          clen = 4'd2 + {1'b0, junk[9:7]};
        end
        default:       acmd = ACMD_GEN;
      endcase
      do_cmd(app, acmd, clen, glen, adata, junk);
    end
  endtask

  ////////////////////
  // Entropy source
  ////////////////////
  initial begin
    logic [31:0] rs;
    int          delay;
    rs = seed + 32'd2 * 32'h9e37_79b9;
    es_ack = 1'b0;
    es_bits = '0;
    forever begin
      @(negedge clk);
      if (!rst && es_req) begin
        rs = xorshift(rs);
        delay = int'(rs % 32'd6);
        repeat (delay) @(negedge clk);
        rs = xorshift(rs);
        es_ack = 1'b1;
        es_bits = rs;
        es_word = rs;
        @(negedge clk);
        es_ack = 1'b0;
        if (es_req) begin
          err_other++;
          $display("ERROR: es_req_o still high the cycle after the entropy ack");
        end
      end
    end
  end

  // Genbits monitor, words must belong to the application's own command
  initial begin
    forever begin
      @(negedge clk);
      for (int i = 0; i < n_apps; i++) begin
        if (!rst && gen_valid[i]) begin
          if (exp_rd[i] >= exp_cnt[i]) begin
            err_other++;
            $display("ERROR: unexpected genbits word %08h on app %0d", gen_bits[i], i);
          end else begin
            check_genbits(i, gen_bits[i], exp_words[i][exp_rd[i]]);
            exp_rd[i]++;
          end
        end
      end
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("ERROR: timeout, run did not finish within %0d cycles", wd_cycles);
    $display("Errors: %0d check failures, %0d other failures", err_check, err_other);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    rst = 1'b1;
    req_valid = '0;
    req_word = '0;
    err_check = 0;
    err_other = 0;
    alert_exp = 1'b0;
    es_word = '0;
    for (int i = 0; i < n_apps; i++) begin
      m_key[i] = '0;
      m_v[i] = '0;
      m_inst[i] = 1'b0;
      exp_cnt[i] = 0;
      exp_rd[i] = 0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_reset_state();

    // Directed sequence
    do_cmd(0, ACMD_GEN, 4'd0, 12'd3, '0, 12'h000);
    do_cmd(0, ACMD_INS, 4'd0, 12'd0, '0, 12'h000);
    do_cmd(0, ACMD_GEN, 4'd0, 12'd4, '0, 12'h000);
    do_cmd(0, ACMD_GEN, 4'd1, 12'd5, 32'h1234_5678, 12'h5a3);
    do_cmd(0, ACMD_UNI, 4'd0, 12'd0, '0, 12'h000);
    do_cmd(0, ACMD_GEN, 4'd0, 12'd2, '0, 12'h000);
    do_cmd(0, ACMD_INS, 4'd1, 12'd0, 32'hdead_beef, 12'h000);
    do_cmd(0, ACMD_GEN, 4'd0, 12'd3, '0, 12'h000);
    do_cmd(1, ACMD_INS, 4'd1, 12'd0, 32'h0f0f_a5a5, 12'h000);
    do_cmd(1, ACMD_GEN, 4'd0, 12'd8, '0, 12'h000);
    do_cmd(0, 4'h7, 4'd0, 12'd0, '0, 12'h000);
    do_cmd(0, ACMD_GEN, 4'd2, 12'd3, '0, 12'h000);
    do_cmd(0, ACMD_GEN, 4'd0, 12'd6, '0, 12'h000);
    do_cmd(0, ACMD_GEN, 4'd1, 12'd0, 32'hcafe_f00d, 12'h000);

    // Both applications at once
    fork
      run_random(0, n_random);
      run_random(1, n_random);
    join

    repeat (5) @(negedge clk);
    check_alert(alert_fatal, alert_exp);
    $display("Errors: %0d check failures, %0d other failures", err_check, err_other);
    if (err_check + err_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+.
csrng_pkg.sv
csrng_app_if.sv
csrng_cmd_stage.sv
csrng_drbg_gen.sv
csrng_core.sv
csrng.sv
tb_csrng.sv

//--- run.sh
#!/usr/bin/env bash
# Build the CSRNG testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module tb_csrng \
  -f files.f -o tb_csrng_sim
./obj_dir/tb_csrng_sim | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"
